// ==== cpu16.f ====
+incdir+include
+incdir+verif
logic/cpu16_isa_pkg.sv
logic/cpu16_bus_pkg.sv
logic/ifid_reg.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/cpu_control.sv
logic/cpu16_top.sv
verif/cpu16_tb.sv

// ==== include/cpu16_settings.svh ====
// Fixed widths and host map tied to the 16-bit encoding; changing them breaks the instruction format
`ifndef CPU16_SETTINGS_SVH
`define CPU16_SETTINGS_SVH

// Data and instruction word
`define CPU16_WORD_W 16

// Instruction memory, in words
`define CPU16_IMEM_DEPTH 256

// APB byte address width
`define CPU16_PADDR_W 12

// Host map, byte addresses, word stride 4
`define CPU16_ADDR_IMEM_BASE 12'h000
`define CPU16_ADDR_CTRL      12'h400 // bit0 = run
`define CPU16_ADDR_STATUS    12'h404
`define CPU16_ADDR_REG_BASE  12'h440 // r0..r15

// CALL link target
`define CPU16_LINK_REG 15

`endif

// ==== logic/cpu16_bus_pkg.sv ====
// Host-side APB types; pwdata/prdata are 32 bits but only the low word reaches the core
`include "cpu16_settings.svh"

package cpu16_bus_pkg;

	typedef struct packed {
		logic                      psel;
		logic                      penable;
		logic                      pwrite;
		logic [`CPU16_PADDR_W-1:0] paddr;
		logic [31:0]               pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready; // Always 1, zero wait states
		logic        pslverr;
	} apb_rsp_t;

	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		RUN    = 2'd1,
		HALTED = 2'd2
	} run_state_e;

	// STATUS register layout
	typedef struct packed {
		logic [15:0] pc;      // Fetch pc
		logic [13:0] rsvd;    // Reads 0
		logic        halted;
		logic        running;
	} status_t;

endpackage

// ==== logic/cpu16_isa_pkg.sv ====
// Instruction-set types; opcode codes C and D have no meaning and decode as NOP
`include "cpu16_settings.svh"

package cpu16_isa_pkg;

	typedef logic [`CPU16_WORD_W-1:0] word_t;

	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_NAND = 4'h2,
		OP_XOR  = 4'h3,
		OP_SLL  = 4'h4,
		OP_SRL  = 4'h5,
		OP_SRA  = 4'h6,
		OP_LLB  = 4'h7,
		OP_LHB  = 4'h8,
		OP_BR   = 4'h9,
		OP_CALL = 4'hA,
		OP_RET  = 4'hB,
		OP_HLT  = 4'hE,
		OP_NOP  = 4'hF
	} opcode_e;

	// Branch conditions, tested against the flags register
	typedef enum logic [2:0] {
		COND_NE, COND_EQ, COND_GT, COND_LT,
		COND_GE, COND_LE, COND_OV, COND_ALWAYS
	} cond_e;

	typedef enum logic [1:0] {
		BK_NONE, BK_BR, BK_CALL, BK_RET
	} br_kind_e;

	// Every view of one instruction word, overlapping
	typedef struct packed {
		opcode_e     opcode; // [15:12]
		cond_e       cond;   // [10:8]
		logic [3:0]  rs;     // [7:4]
		logic [3:0]  rt;     // [3:0]
		logic [3:0]  rd;     // [11:8]
		logic [3:0]  imm4;   // [3:0], shift amount
		logic [7:0]  imm8;   // [7:0], load byte or branch offset
		logic [11:0] target; // [11:0], CALL absolute
	} id_fields_t;

	typedef struct packed {
		opcode_e     op;
		logic [3:0]  rd;
		logic        we;
		logic        flag_we; // ALU ops only
		br_kind_e    br;
		cond_e       cond;
		logic [3:0]  imm4;
		logic [7:0]  imm8;
		logic [11:0] target;
		word_t       pc;      // Address of this instruction
	} ex_ctrl_t;

	typedef struct packed {
		logic       we;
		logic [3:0] rd;
		word_t      data;
	} wb_t;

	typedef struct packed {
		logic z;
		logic n;
		logic v;
	} flags_t;

	// Bubble loaded into ID/EX on reset and flush
	localparam ex_ctrl_t EX_BUBBLE = '{
		op: OP_NOP, rd: '0, we: 1'b0, flag_we: 1'b0, br: BK_NONE,
		cond: COND_NE, imm4: '0, imm8: '0, target: '0, pc: '0
	};

endpackage

// ==== logic/cpu16_top.sv ====
// Core top; host access only through the APB port, no other I/O
`timescale 1ns/10ps
`include "cpu16_settings.svh"

module cpu16_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  cpu16_bus_pkg::apb_req_t host_req,
	output cpu16_bus_pkg::apb_rsp_t host_rsp
);
	import cpu16_isa_pkg::*;

	localparam int AW = $clog2(`CPU16_IMEM_DEPTH);

	id_fields_t fields;
	ex_ctrl_t   ex_ctrl;
	wb_t        wb;
	word_t      pc, instruction, id_pc;
	word_t      op_a, op_b, host_data;
	word_t      ex_redirect_pc, fetch_redirect_pc, imem_wdata;
	logic       hazard, flush, halt_seen, imem_we;
	logic       ex_redirect_valid, start_redirect, fetch_redirect_valid;
	logic [AW-1:0] imem_addr;
	logic [3:0] rd_addr_b, host_addr;

	// Start wins and restarts at 0
	assign fetch_redirect_valid = ex_redirect_valid || start_redirect;
	assign fetch_redirect_pc    = start_redirect ? '0 : ex_redirect_pc;

	cpu_control i_control (
		.clk(clk), .rst_n(rst_n),
		.host_req(host_req), .host_rsp(host_rsp),
		.fields(fields), .id_pc(id_pc), .pc(pc),
		.redirect_valid_ex(ex_redirect_valid), .halt_seen(halt_seen),
		.hazard(hazard), .flush(flush), .start_redirect(start_redirect),
		.rd_addr_b(rd_addr_b), .ctrl_out(ex_ctrl),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
		.host_addr(host_addr), .host_data(host_data)
	);

	fetch_unit i_fetch (
		.clk(clk), .rst_n(rst_n), .hazard(hazard),
		.redirect_valid(fetch_redirect_valid), .redirect_pc(fetch_redirect_pc),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
		.pc(pc), .instruction(instruction)
	);

	ifid_reg i_ifid (
		.clk(clk), .rst_n(rst_n), .hazard(hazard), .flush(flush),
		.instruction(instruction), .pc_in(pc),
		.fields(fields), .pc_out(id_pc)
	);

	reg_file i_regs (
		.clk(clk), .rst_n(rst_n),
		.rd_addr_a(fields.rs), .rd_addr_b(rd_addr_b), .host_addr(host_addr),
		.wb(wb),
		.rd_data_a(op_a), .rd_data_b(op_b), .host_data(host_data)
	);

	exec_unit i_exec (
		.clk(clk), .rst_n(rst_n), .hazard(hazard), .flush(flush),
		.ctrl_in(ex_ctrl), .op_a(op_a), .op_b(op_b),
		.wb(wb),
		.redirect_valid(ex_redirect_valid), .redirect_pc(ex_redirect_pc),
		.halt_seen(halt_seen)
	);

endmodule

// ==== logic/cpu_control.sv ====
// Controller and APB slave; zero wait states, imem is write-only and only while not running
`timescale 1ns/10ps
`include "cpu16_settings.svh"

module cpu_control (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  cpu16_bus_pkg::apb_req_t              host_req,
	output cpu16_bus_pkg::apb_rsp_t              host_rsp,
	input  cpu16_isa_pkg::id_fields_t            fields,
	input  cpu16_isa_pkg::word_t                 id_pc,
	input  cpu16_isa_pkg::word_t                 pc,
	input  logic                                 redirect_valid_ex,
	input  logic                                 halt_seen,
	output logic                                 hazard,
	output logic                                 flush,
	output logic                                 start_redirect, // pc to 0
	output logic [3:0]                           rd_addr_b,
	output cpu16_isa_pkg::ex_ctrl_t              ctrl_out,
	output logic                                 imem_we,
	output logic [$clog2(`CPU16_IMEM_DEPTH)-1:0] imem_addr,
	output cpu16_isa_pkg::word_t                 imem_wdata,
	output logic [3:0]                           host_addr,
	input  cpu16_isa_pkg::word_t                 host_data
);
	import cpu16_isa_pkg::*;
	import cpu16_bus_pkg::*;

	localparam int AW = $clog2(`CPU16_IMEM_DEPTH);

	run_state_e state;
	status_t    status;
	logic       access, running;
	logic       hit_imem, hit_ctrl, hit_status, hit_regs;
	logic       start, stop;

	// Decode
	always_comb begin
		ctrl_out.op      = fields.opcode;
		ctrl_out.rd      = fields.rd;
		ctrl_out.we      = 1'b0;
		ctrl_out.flag_we = 1'b0;
		ctrl_out.br      = BK_NONE;
		ctrl_out.cond    = fields.cond;
		ctrl_out.imm4    = fields.imm4;
		ctrl_out.imm8    = fields.imm8;
		ctrl_out.target  = fields.target;
		ctrl_out.pc      = id_pc;
		rd_addr_b        = fields.rt;
		case (fields.opcode)
			OP_ADD, OP_SUB, OP_NAND, OP_XOR: begin
				ctrl_out.we      = 1'b1;
				ctrl_out.flag_we = 1'b1;
			end
			OP_SLL, OP_SRL, OP_SRA, OP_LLB: ctrl_out.we = 1'b1;
			OP_LHB: begin
				ctrl_out.we = 1'b1;
				rd_addr_b   = fields.rd; // Keep old low byte
			end
			OP_BR: ctrl_out.br = BK_BR;
			OP_CALL: begin
				ctrl_out.we = 1'b1;
				ctrl_out.rd = 4'(`CPU16_LINK_REG);
				ctrl_out.br = BK_CALL;
			end
			OP_RET: begin
				ctrl_out.br = BK_RET;
				rd_addr_b   = 4'(`CPU16_LINK_REG);
			end
			OP_HLT: ;                         // Handled in execute
			default: ctrl_out.op = OP_NOP;    // C, D, NOP
		endcase
	end

	// APB access phase and address decode
	assign access     = host_req.psel && host_req.penable;
	assign hit_imem   = host_req.paddr < `CPU16_ADDR_IMEM_BASE + 4 * `CPU16_IMEM_DEPTH;
	assign hit_ctrl   = host_req.paddr == `CPU16_ADDR_CTRL;
	assign hit_status = host_req.paddr == `CPU16_ADDR_STATUS;
	assign hit_regs   = host_req.paddr >= `CPU16_ADDR_REG_BASE &&
	                    host_req.paddr <  `CPU16_ADDR_REG_BASE + 12'h040;

	assign start = access && host_req.pwrite && hit_ctrl && host_req.pwdata[0];
	assign stop  = access && host_req.pwrite && hit_ctrl && !host_req.pwdata[0];

	// Run state
	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= IDLE;
		else if (start)
			state <= RUN;           // Also a restart
		else if (stop)
			state <= IDLE;
		else if (state == RUN && halt_seen)
			state <= HALTED;
	end

	assign running        = state == RUN;
	assign hazard         = !running;
	assign start_redirect = start;
	assign flush          = redirect_valid_ex || start; // Two-slot kill

	assign imem_we    = access && host_req.pwrite && hit_imem && !running;
	assign imem_addr  = host_req.paddr[AW+1:2];
	assign imem_wdata = host_req.pwdata[15:0];
	assign host_addr  = host_req.paddr[5:2];

	assign status.pc      = pc;
	assign status.rsvd    = '0;
	assign status.halted  = state == HALTED;
	assign status.running = running;

	always_comb begin
		host_rsp.pready  = 1'b1;
		host_rsp.prdata  = '0;
		host_rsp.pslverr = 1'b0;
		if (access) begin
			if (hit_imem) begin
				host_rsp.pslverr = !host_req.pwrite || running; // Write-only, idle only
			end else if (hit_ctrl) begin
				if (!host_req.pwrite)
					host_rsp.prdata = 32'(state);
			end else if (hit_status) begin
				host_rsp.pslverr = host_req.pwrite;
				if (!host_req.pwrite)
					host_rsp.prdata = status;
			end else if (hit_regs) begin
				host_rsp.pslverr = host_req.pwrite;
				if (!host_req.pwrite)
					host_rsp.prdata = 32'(host_data);
			end else begin
				host_rsp.pslverr = 1'b1; // Unmapped
			end
		end
	end

endmodule

// ==== logic/exec_unit.sv ====
// Execute stage; nothing writes or redirects while hazard is high, HLT redirects to itself
`timescale 1ns/10ps

module exec_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    hazard,
	input  logic                    flush,
	input  cpu16_isa_pkg::ex_ctrl_t ctrl_in,
	input  cpu16_isa_pkg::word_t    op_a,
	input  cpu16_isa_pkg::word_t    op_b,
	output cpu16_isa_pkg::wb_t      wb,
	output logic                    redirect_valid,
	output cpu16_isa_pkg::word_t    redirect_pc,
	output logic                    halt_seen
);
	import cpu16_isa_pkg::*;

	localparam int MSB = $bits(word_t) - 1;

	ex_ctrl_t ctrl_q;
	word_t    a_q, b_q;
	flags_t   flags, alu_flags;
	word_t    result, next_pc, br_target;
	logic     active, cond_ok;

	// ID/EX register
	always_ff @(posedge clk) begin
		if (!rst_n || flush)
			ctrl_q <= EX_BUBBLE;
		else if (!hazard)
			ctrl_q <= ctrl_in;
	end

	always_ff @(posedge clk) begin
		if (!hazard) begin
			a_q <= op_a;
			b_q <= op_b;
		end
	end

	assign active    = !hazard;
	assign next_pc   = ctrl_q.pc + 1'b1;
	assign br_target = next_pc + {{8{ctrl_q.imm8[7]}}, ctrl_q.imm8}; // Relative to pc+1

	always_comb begin
		result    = '0;
		alu_flags = flags;
		case (ctrl_q.op)
			OP_ADD: begin
				result      = a_q + b_q;
				alu_flags.v = (a_q[MSB] == b_q[MSB]) && (result[MSB] != a_q[MSB]);
			end
			OP_SUB: begin
				result      = a_q - b_q;
				alu_flags.v = (a_q[MSB] != b_q[MSB]) && (result[MSB] != a_q[MSB]);
			end
			OP_NAND: begin
				result      = ~(a_q & b_q);
				alu_flags.v = 1'b0;
			end
			OP_XOR: begin
				result      = a_q ^ b_q;
				alu_flags.v = 1'b0;
			end
			OP_SLL:  result = a_q << ctrl_q.imm4;
			OP_SRL:  result = a_q >> ctrl_q.imm4;
			OP_SRA:  result = word_t'($signed(a_q) >>> ctrl_q.imm4);
			OP_LLB:  result = {{8{ctrl_q.imm8[7]}}, ctrl_q.imm8};
			OP_LHB:  result = {ctrl_q.imm8, b_q[7:0]}; // b carries old rd
			OP_CALL: result = next_pc;                 // Link value
			default: result = '0;
		endcase
		alu_flags.z = (result == '0);
		alu_flags.n = result[MSB];
	end

	// Only ALU ops touch the flags
	always_ff @(posedge clk) begin
		if (!rst_n)
			flags <= '0;
		else if (active && ctrl_q.flag_we)
			flags <= alu_flags;
	end

	always_comb begin
		case (ctrl_q.cond)
			COND_NE: cond_ok = !flags.z;
			COND_EQ: cond_ok = flags.z;
			COND_GT: cond_ok = !flags.z && !flags.n;
			COND_LT: cond_ok = flags.n;
			COND_GE: cond_ok = !flags.n;
			COND_LE: cond_ok = flags.n || flags.z;
			COND_OV: cond_ok = flags.v;
			default: cond_ok = 1'b1; // ALWAYS
		endcase
	end

	always_comb begin
		redirect_valid = 1'b0;
		redirect_pc    = next_pc;
		case (ctrl_q.br)
			BK_BR: begin
				redirect_valid = active && cond_ok;
				redirect_pc    = br_target;
			end
			BK_CALL: begin
				redirect_valid = active;
				redirect_pc    = {4'b0, ctrl_q.target};
			end
			BK_RET: begin
				redirect_valid = active;
				redirect_pc    = b_q; // r15
			end
			default: begin
				// Park the pc on the HLT
				redirect_valid = active && ctrl_q.op == OP_HLT;
				redirect_pc    = ctrl_q.pc;
			end
		endcase
	end

	assign halt_seen = active && ctrl_q.op == OP_HLT;

	assign wb.we   = active && ctrl_q.we;
	assign wb.rd   = ctrl_q.rd;
	assign wb.data = result;

endmodule

// ==== logic/fetch_unit.sv ====
// Fetch stage; imem read is asynchronous and the pc wraps at the memory depth for the read
`timescale 1ns/10ps
`include "cpu16_settings.svh"

module fetch_unit (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                hazard,
	input  logic                                redirect_valid, // Branch, halt or start
	input  cpu16_isa_pkg::word_t                redirect_pc,
	input  logic                                imem_we,        // Host load
	input  logic [$clog2(`CPU16_IMEM_DEPTH)-1:0] imem_addr,
	input  cpu16_isa_pkg::word_t                imem_wdata,
	output cpu16_isa_pkg::word_t                pc,
	output cpu16_isa_pkg::word_t                instruction
);
	import cpu16_isa_pkg::*;

	localparam int AW = $clog2(`CPU16_IMEM_DEPTH);

	word_t imem [`CPU16_IMEM_DEPTH];

	// Host port, independent of the pc
	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	assign instruction = imem[pc[AW-1:0]];

	// Redirect beats stall and increment
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (redirect_valid) begin
			pc <= redirect_pc;
		end else if (!hazard) begin
			pc <= pc + 1'b1;
		end
	end

endmodule

// ==== logic/ifid_reg.sv ====
// Decode latch; flush beats stall, and reset or flush loads the NOP word F000
`timescale 1ns/10ps

module ifid_reg (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      hazard,      // Core not running, hold
	input  logic                      flush,       // Kill the fetched word
	input  cpu16_isa_pkg::word_t      instruction,
	input  cpu16_isa_pkg::word_t      pc_in,
	output cpu16_isa_pkg::id_fields_t fields,
	output cpu16_isa_pkg::word_t      pc_out
);
	import cpu16_isa_pkg::*;

	localparam word_t NOP_WORD = 16'hF000;

	// Cut all views at once, decode picks what the opcode needs
	function automatic id_fields_t split(input word_t w);
		id_fields_t f;
		f.opcode = opcode_e'(w[15:12]);
		f.cond   = cond_e'(w[10:8]);
		f.rs     = w[7:4];
		f.rt     = w[3:0];
		f.rd     = w[11:8];
		f.imm4   = w[3:0];
		f.imm8   = w[7:0];
		f.target = w[11:0];
		return f;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			fields <= split(NOP_WORD); // Bubble
			pc_out <= '0;
		end else if (!hazard) begin
			fields <= split(instruction);
			pc_out <= pc_in;
		end
		// Stall keeps both
	end

endmodule

// ==== logic/reg_file.sv ====
// Sixteen registers, one write port; all reads see a same-cycle write (write-through)
`timescale 1ns/10ps

module reg_file (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [3:0]           rd_addr_a, // rs
	input  logic [3:0]           rd_addr_b, // rt, rd or link
	input  logic [3:0]           host_addr,
	input  cpu16_isa_pkg::wb_t   wb,
	output cpu16_isa_pkg::word_t rd_data_a,
	output cpu16_isa_pkg::word_t rd_data_b,
	output cpu16_isa_pkg::word_t host_data
);
	import cpu16_isa_pkg::*;

	word_t regs [16];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wb.we) begin
			regs[wb.rd] <= wb.data; // r0 is ordinary
		end
	end

	// Bypass so decode never waits on execute
	assign rd_data_a = (wb.we && wb.rd == rd_addr_a) ? wb.data : regs[rd_addr_a];
	assign rd_data_b = (wb.we && wb.rd == rd_addr_b) ? wb.data : regs[rd_addr_b];
	assign host_data = (wb.we && wb.rd == host_addr) ? wb.data : regs[host_addr];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the cpu16 testbench with Verilator; the verdict comes from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cpu16_tb -f cpu16.f -Mdir obj_dir \
	> build.log 2>&1 \
	&& ./obj_dir/Vcpu16_tb > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "TEST RESULT: PASS" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// ==== verif/cpu16_programs.svh ====
// Program table as raw words; registers and flags carry over between entries, so order matters

localparam int NPROG = 5;
localparam logic [`CPU16_PADDR_W-1:0] POKE_ADDR = 12'h010; // Word 4 of run_protect
localparam word_t POKE_WORD = 16'h7722;                    // LLB r7, 0x22

typedef logic [19:0] reg_chk_t; // {reg, expected value}

string    cur_name;
word_t    cur_code[$];
reg_chk_t cur_chk[$];
word_t    cur_halt;  // Address of the HLT
logic     cur_poke;  // Host imem write while running

task automatic select_program(input int idx);
	word_t sum, diff, nand_v, xor_v;
	sum      = rand_a + rand_b;  // Modulo 2^16
	diff     = sum - rand_a;
	nand_v   = ~(diff & sum);
	xor_v    = nand_v ^ rand_a;
	cur_poke = 1'b0;
	case (idx)
		0: begin // Shifts and LHB after an ADD that sets z
			cur_name = "shift_lhb";
			cur_code = '{16'h7181, 16'h8196, 16'h7900, 16'h0999, 16'h4214, 16'h5314,
				16'h6414, 16'h651F, 16'h4610, 16'h5719, 16'h7834, 16'h88AB,
				16'h9101, 16'h7A01, 16'h7B02, 16'hE000};
			cur_halt = 16'd15;
			cur_chk  = '{20'h1_9681, 20'h2_6810, 20'h3_0968, 20'h4_F968, 20'h5_FFFF,
				20'h6_9681, 20'h7_004B, 20'h8_AB34, 20'hA_0000, 20'hB_0002};
		end
		1: begin // Dependent chain on random operands, then SUB overflow and BR OV
			cur_name = "alu_random";
			cur_code = '{{8'h71, rand_a[7:0]}, {8'h81, rand_a[15:8]},
				{8'h72, rand_b[7:0]}, {8'h82, rand_b[15:8]},
				16'h0312, 16'h1431, 16'h2543, 16'h3651, 16'h7800, 16'h8880,
				16'h7901, 16'h1A89, 16'h9602, 16'h73FF, 16'h74FF, 16'h7B5A, 16'hE000};
			cur_halt = 16'd16;
			cur_chk  = '{{4'h1, rand_a}, {4'h2, rand_b}, {4'h3, sum}, {4'h4, diff},
				{4'h5, nand_v}, {4'h6, xor_v}, 20'h8_8000, 20'hA_7FFF, 20'hB_005A};
		end
		2: begin // Not-taken case of each condition before its taken case
			cur_name = "branch_cond";
			cur_code = '{16'h79FF, 16'h897F, 16'h7A01, 16'h7817, 16'h0B9A, 16'h9101,
				16'h7211, 16'h9401, 16'h7514, 16'h9201, 16'h7312, 16'h1BAA,
				16'h9001, 16'h7110, 16'h9101, 16'h72EE, 16'h9401, 16'h75EE,
				16'h0BAA, 16'h9001, 16'h71EE, 16'h9201, 16'h73EE, 16'h9301,
				16'h7413, 16'h9501, 16'h7615, 16'h9601, 16'h7716, 16'h0B9A,
				16'h9301, 16'h74EE, 16'h9501, 16'h76EE, 16'h9601, 16'h77EE,
				16'h9701, 16'h78EE, 16'hE000};
			cur_halt = 16'd38;
			cur_chk  = '{20'h1_0010, 20'h2_0011, 20'h3_0012, 20'h4_0013, 20'h5_0014,
				20'h6_0015, 20'h7_0016, 20'h8_0017, 20'hB_8000};
		end
		3: begin // CALL to 4, RET back to 2
			cur_name = "call_ret";
			cur_code = '{16'h7105, 16'hA004, 16'h7209, 16'hE000, 16'h0311, 16'hB000,
				16'h73EE, 16'h7FEE};
			cur_halt = 16'd3;
			cur_chk  = '{20'h1_0005, 20'h2_0009, 20'h3_000A, 20'hF_0002};
		end
		4: begin // Countdown loop, long enough for a host write mid-run
			cur_name = "run_protect";
			cur_code = '{16'h7114, 16'h7201, 16'h1112, 16'h90FE, 16'h7711, 16'hE000};
			cur_halt = 16'd5;
			cur_poke = 1'b1;
			cur_chk  = '{20'h1_0000, 20'h2_0001, 20'h7_0011};
		end
		default: begin
			cur_name = "empty";
			cur_code = {};
			cur_halt = '0;
			cur_chk  = {};
		end
	endcase
endtask

// ==== verif/cpu16_tb.sv ====
// Loads each table program over APB, runs it to HLT and reads back registers; no wait states
`timescale 1ns/10ps
`include "cpu16_settings.svh"

module cpu16_tb;
	import cpu16_isa_pkg::*;
	import cpu16_bus_pkg::*;

	logic     clk;
	logic     rst_n;
	apb_req_t req;
	apb_rsp_t rsp;

	int    cycles;
	int    cycle_limit;
	int    word_errs;
	int    status_errs;
	int    resp_errs;
	word_t rand_a, rand_b; // Entry 1 operands

	`include "cpu16_programs.svh"

	cpu16_top i_dut (.clk(clk), .rst_n(rst_n), .host_req(req), .host_rsp(rsp));

	always #50 clk = ~clk; // 100 ns

	// Watchdog over the whole run
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("ERROR: timeout after %0d cycles, the core never reported halted", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic apb_write(input logic [`CPU16_PADDR_W-1:0] addr, input logic [31:0] data,
	                         output logic err);
		@(posedge clk);
		req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data}; // Setup
		@(posedge clk);
		req.penable <= 1'b1; // Access
		@(negedge clk);
		err = rsp.pslverr;
		if (rsp.pready !== 1'b1) begin
			resp_errs++;
			$display("FAILED apb write at %h: expected pready 1, actual %b", addr, rsp.pready);
		end
		@(posedge clk);
		req <= '0;
	endtask

	task automatic apb_read(input logic [`CPU16_PADDR_W-1:0] addr, output logic [31:0] data,
	                        output logic err);
		@(posedge clk);
		req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
		@(posedge clk);
		req.penable <= 1'b1;
		@(negedge clk);
		data = rsp.prdata; // Mid access cycle
		err  = rsp.pslverr;
		if (rsp.pready !== 1'b1) begin
			resp_errs++;
			$display("FAILED apb read at %h: expected pready 1, actual %b", addr, rsp.pready);
		end
		@(posedge clk);
		req <= '0;
	endtask

	function automatic logic [`CPU16_PADDR_W-1:0] reg_addr(input logic [3:0] r);
		return `CPU16_ADDR_REG_BASE + {r, 2'b00};
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			word_errs++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input status_t exp, input status_t act);
		if (act !== exp) begin
			status_errs++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			resp_errs++;
			$display("FAILED %s: expected pslverr %b, actual %b", name, exp, act);
		end
	endtask

	// Start, optional mid-run imem write, poll for halt, read back
	task automatic run_and_check(input string tag);
		logic        err;
		logic [31:0] data;
		status_t     st, exp_st;
		apb_write(`CPU16_ADDR_CTRL, 32'h1, err);
		check_resp({tag, " start"}, 1'b0, err);
		if (cur_poke) begin
			apb_write(POKE_ADDR, 32'(POKE_WORD), err);
			check_resp({tag, " imem write while running"}, 1'b1, err);
		end
		do begin
			apb_read(`CPU16_ADDR_STATUS, data, err);
			st = status_t'(data);
		end while (!st.halted);
		exp_st         = '0;
		exp_st.pc      = cur_halt; // Parked on the HLT
		exp_st.halted  = 1'b1;
		check_status({tag, " status"}, exp_st, st);
		foreach (cur_chk[i]) begin
			apb_read(reg_addr(cur_chk[i][19:16]), data, err);
			check_resp($sformatf("%s r%0d read", tag, cur_chk[i][19:16]), 1'b0, err);
			check_word($sformatf("%s r%0d", tag, cur_chk[i][19:16]), cur_chk[i][15:0], data[15:0]);
		end
	endtask

	initial begin
		logic        err;
		logic [31:0] data;
		int          total;
		status_t     exp_st;
		clk         = 1'b0;
		rst_n       = 1'b0;
		req         = '0;
		cycles      = 0;
		word_errs   = 0;
		status_errs = 0;
		resp_errs   = 0;
		void'($urandom(32'ha0894300));
		rand_a = word_t'($urandom);
		rand_b = word_t'($urandom);
		total  = 0;
		for (int p = 0; p < NPROG; p++) begin
			select_program(p);
			total += cur_code.size();
		end
		cycle_limit = 40 * total + 200;

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// Post-reset state
		apb_read(`CPU16_ADDR_STATUS, data, err);
		check_resp("reset status read", 1'b0, err);
		check_status("reset status", status_t'(32'h0), status_t'(data));
		for (int r = 0; r < 16; r++) begin
			apb_read(reg_addr(4'(r)), data, err);
			check_resp($sformatf("reset r%0d read", r), 1'b0, err);
			check_word($sformatf("reset r%0d", r), 16'h0000, data[15:0]);
		end

		for (int p = 0; p < NPROG; p++) begin
			select_program(p);
			foreach (cur_code[i]) begin
				apb_write(`CPU16_ADDR_IMEM_BASE + 12'(4 * i), 32'(cur_code[i]), err);
				check_resp($sformatf("%s load word %0d", cur_name, i), 1'b0, err);
			end
			run_and_check(cur_name);
		end

		// Host error responses
		apb_write(`CPU16_ADDR_STATUS, 32'h1, err);
		check_resp("status write", 1'b1, err);
		apb_write(12'h800, 32'h1234, err);
		check_resp("unmapped write", 1'b1, err);
		apb_read(12'h800, data, err);
		check_resp("unmapped read", 1'b1, err);
		check_word("unmapped read data", 16'h0000, data[15:0]);

		// Stop drops to IDLE, pc stays on the HLT
		apb_write(`CPU16_ADDR_CTRL, 32'h0, err);
		check_resp("stop write", 1'b0, err);
		apb_read(`CPU16_ADDR_STATUS, data, err);
		exp_st    = '0;
		exp_st.pc = cur_halt;
		check_status("idle status", exp_st, status_t'(data));

		// Halted again only if the second start really ran the program
		cur_poke = 1'b0;
		run_and_check({cur_name, " rerun"});

		$display("Errors: word %0d, status %0d, response %0d", word_errs, status_errs, resp_errs);
		if (word_errs + status_errs + resp_errs == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
